/* logic/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    localparam int XLEN = 32;

    // one machine word, used for register contents, operands and pc
    typedef logic [XLEN-1:0] xlen_t;

    // csr address field of the instruction
    typedef logic [11:0] csr_addr_t;

    // machine-mode registers that exist in this unit
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    // mpp field of mstatus, bits 12 and 11
    localparam xlen_t MSTATUS_MPP_MASK = 32'h0000_1800;

    // environment call from machine mode
    localparam xlen_t CAUSE_ECALL_M = 32'd11;

endpackage

`default_nettype wire

/* logic/sys_isa_pkg.sv */
`default_nettype none

package sys_isa_pkg;

    typedef logic [31:0] inst_t;

    localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

    // funct3 of the SYSTEM opcode, 3'b100 is reserved
    typedef enum logic [2:0] {
        PRIV   = 3'b000,
        CSRRW  = 3'b001,
        CSRRS  = 3'b010,
        CSRRC  = 3'b011,
        CSRRWI = 3'b101,
        CSRRSI = 3'b110,
        CSRRCI = 3'b111
    } funct3_e;

    // what the csr file has to do with one instruction
    typedef enum logic [2:0] {
        NOP,
        CSR_WRITE,
        CSR_SET,
        CSR_CLEAR,
        ECALL,
        MRET
    } sys_op_e;

    // imm[11:0] values that tell the privileged instructions apart
    localparam logic [11:0] IMM_ECALL = 12'h000;
    localparam logic [11:0] IMM_MRET  = 12'h302;

endpackage

`default_nettype wire

/* logic/sys_op_if.sv */
`default_nettype none

// one decoded SYSTEM operation, valid/ready handshake
interface sys_op_if;
    import csr_pkg::*;
    import sys_isa_pkg::*;

    logic      valid;
    sys_op_e   op;
    csr_addr_t addr;
    xlen_t     operand;
    xlen_t     pc;
    logic      ready;

    modport driver (
        output valid,
        output op,
        output addr,
        output operand,
        output pc,
        input  ready
    );

    modport receiver (
        input  valid,
        input  op,
        input  addr,
        input  operand,
        input  pc,
        output ready
    );

endinterface

`default_nettype wire

/* logic/sys_decode.sv */
`default_nettype none

module sys_decode #(
    parameter int IN_DEPTH = 2
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 i_valid,
    input  wire sys_isa_pkg::inst_t   i_inst,
    input  wire csr_pkg::xlen_t       i_rs1_data,
    input  wire csr_pkg::xlen_t       i_pc,
    output logic                      o_credit,
    sys_op_if.driver                  op
);
    import csr_pkg::*;
    import sys_isa_pkg::*;

    localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CNT_W = $clog2(IN_DEPTH + 1);

    inst_t buf_inst [IN_DEPTH];
    xlen_t buf_rs1  [IN_DEPTH];
    xlen_t buf_pc   [IN_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    inst_t      head_inst;
    funct3_e    funct3;
    logic [4:0] rs1_field;
    sys_op_e    dec_op;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(IN_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign pop = op.valid && op.ready;

    always_ff @(posedge clk) begin
        if (i_valid) begin
            buf_inst[wr_ptr] <= i_inst;
            buf_rs1[wr_ptr]  <= i_rs1_data;
            buf_pc[wr_ptr]   <= i_pc;
        end
    end

    // the sender never exceeds its credits, so a write always finds room
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end else begin
            if (i_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count    <= count + CNT_W'(i_valid) - CNT_W'(pop);
            o_credit <= pop;
        end
    end

    assign head_inst = buf_inst[rd_ptr];
    assign funct3    = funct3_e'(head_inst[14:12]);
    assign rs1_field = head_inst[19:15];

    always_comb begin
        dec_op = NOP;
        if (head_inst[6:0] == OPC_SYSTEM) begin
            case (funct3)
                PRIV: begin
                    if (head_inst[31:20] == IMM_ECALL) begin
                        dec_op = ECALL;
                    end else if (head_inst[31:20] == IMM_MRET) begin
                        dec_op = MRET;
                    end
                end
                CSRRW, CSRRWI: dec_op = CSR_WRITE;
                CSRRS, CSRRSI: dec_op = CSR_SET;
                CSRRC, CSRRCI: dec_op = CSR_CLEAR;
                default:       dec_op = NOP;
            endcase
        end
    end

    assign op.valid = (count != '0);
    assign op.op    = dec_op;
    assign op.addr  = head_inst[31:20];
    assign op.pc    = buf_pc[rd_ptr];

    // funct3 bit 2 selects the immediate forms, which use the rs1 field itself
    assign op.operand = head_inst[14] ? xlen_t'(rs1_field) : buf_rs1[rd_ptr];

endmodule

`default_nettype wire

/* logic/csr_file.sv */
`default_nettype none

module csr_file (
    input  wire logic        clk,
    input  wire logic        rst_n,
    sys_op_if.receiver       op,
    output logic             o_push,
    output csr_pkg::xlen_t   o_rd_data,
    output logic             o_redirect,
    output csr_pkg::xlen_t   o_target,
    input  wire logic        i_full
);
    import csr_pkg::*;
    import sys_isa_pkg::*;

    xlen_t mstatus;
    xlen_t mtvec;
    xlen_t mepc;
    xlen_t mcause;

    logic  xfer;
    logic  is_csr_op;
    xlen_t old_val;
    xlen_t new_val;

    assign op.ready = !i_full;
    assign xfer     = op.valid && op.ready;

    assign is_csr_op = (op.op == CSR_WRITE) || (op.op == CSR_SET) || (op.op == CSR_CLEAR);

    // unknown addresses read as zero
    always_comb begin
        case (op.addr)
            CSR_MSTATUS: old_val = mstatus;
            CSR_MTVEC:   old_val = mtvec;
            CSR_MEPC:    old_val = mepc;
            CSR_MCAUSE:  old_val = mcause;
            default:     old_val = '0;
        endcase
    end

    // a set or clear with a zero operand leaves the register as it was
    always_comb begin
        case (op.op)
            CSR_SET:   new_val = old_val | op.operand;
            CSR_CLEAR: new_val = old_val & ~op.operand;
            default:   new_val = op.operand;
        endcase
    end

    // the response enters the queue on the same edge that updates the registers
    assign o_push     = xfer;
    assign o_rd_data  = is_csr_op ? old_val : '0;
    assign o_redirect = (op.op == ECALL) || (op.op == MRET);

    always_comb begin
        case (op.op)
            ECALL:   o_target = mtvec;
            MRET:    o_target = mepc;
            default: o_target = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (xfer) begin
            case (op.op)
                ECALL: begin
                    mstatus <= mstatus | MSTATUS_MPP_MASK;
                    mepc    <= op.pc;
                    mcause  <= CAUSE_ECALL_M;
                end
                MRET: begin
                    mstatus <= mstatus & ~MSTATUS_MPP_MASK;
                end
                CSR_WRITE, CSR_SET, CSR_CLEAR: begin
                    // writes to addresses outside the four registers are dropped
                    case (op.addr)
                        CSR_MSTATUS: mstatus <= new_val;
                        CSR_MTVEC:   mtvec   <= new_val;
                        CSR_MEPC:    mepc    <= new_val;
                        CSR_MCAUSE:  mcause  <= new_val;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/sys_resp_queue.sv */
`default_nettype none

module sys_resp_queue #(
    parameter int RESP_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             i_push,
    input  wire csr_pkg::xlen_t   i_rd_data,
    input  wire logic             i_redirect,
    input  wire csr_pkg::xlen_t   i_target,
    output logic                  o_full,
    output logic                  o_valid,
    output csr_pkg::xlen_t        o_rd_data,
    output logic                  o_redirect,
    output csr_pkg::xlen_t        o_target,
    input  wire logic             i_credit
);
    import csr_pkg::*;

    localparam int PTR_W = (RESP_DEPTH > 1) ? $clog2(RESP_DEPTH) : 1;
    localparam int CNT_W = $clog2(RESP_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    xlen_t mem_rd_data  [RESP_DEPTH];
    logic  mem_redirect [RESP_DEPTH];
    xlen_t mem_target   [RESP_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credits;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(RESP_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // a response leaves only when the consumer has room for it
    assign pop     = (count != '0) && (credits != '0);
    assign o_valid = pop;
    assign o_full  = (count == CNT_W'(RESP_DEPTH));

    assign o_rd_data  = mem_rd_data[rd_ptr];
    assign o_redirect = mem_redirect[rd_ptr];
    assign o_target   = mem_target[rd_ptr];

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem_rd_data[wr_ptr]  <= i_rd_data;
            mem_redirect[wr_ptr] <= i_redirect;
            mem_target[wr_ptr]   <= i_target;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + CNT_W'(i_push) - CNT_W'(pop);
        end
    end

    // saturates at the grant so a stray credit cannot wrap the counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= CRD_W'(OUT_CREDITS);
        end else if (i_credit && !pop) begin
            if (credits != CRD_W'(OUT_CREDITS)) begin
                credits <= credits + 1'b1;
            end
        end else if (pop && !i_credit) begin
            credits <= credits - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* logic/csr_unit_top.sv */
`default_nettype none

module csr_unit_top #(
    parameter int IN_DEPTH    = 2,
    parameter int RESP_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 i_in_valid,
    input  wire sys_isa_pkg::inst_t   i_in_inst,
    input  wire csr_pkg::xlen_t       i_in_rs1_data,
    input  wire csr_pkg::xlen_t       i_in_pc,
    output logic                      o_in_credit,
    output logic                      o_resp_valid,
    output csr_pkg::xlen_t            o_resp_rd_data,
    output logic                      o_resp_redirect,
    output csr_pkg::xlen_t            o_resp_target,
    input  wire logic                 i_out_credit
);
    import csr_pkg::*;

    logic  push;
    xlen_t rd_data;
    logic  redirect;
    xlen_t target;
    logic  full;

    sys_op_if op_if ();

    sys_decode #(
        .IN_DEPTH (IN_DEPTH)
    ) u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_valid    (i_in_valid),
        .i_inst     (i_in_inst),
        .i_rs1_data (i_in_rs1_data),
        .i_pc       (i_in_pc),
        .o_credit   (o_in_credit),
        .op         (op_if.driver)
    );

    csr_file u_csr_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .op         (op_if.receiver),
        .o_push     (push),
        .o_rd_data  (rd_data),
        .o_redirect (redirect),
        .o_target   (target),
        .i_full     (full)
    );

    sys_resp_queue #(
        .RESP_DEPTH  (RESP_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_resp_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_push     (push),
        .i_rd_data  (rd_data),
        .i_redirect (redirect),
        .i_target   (target),
        .o_full     (full),
        .o_valid    (o_resp_valid),
        .o_rd_data  (o_resp_rd_data),
        .o_redirect (o_resp_redirect),
        .o_target   (o_resp_target),
        .i_credit   (i_out_credit)
    );

endmodule

`default_nettype wire

/* verif/csr_unit_assertions.sv */
`default_nettype none

module csr_unit_assertions #(
    parameter int RESP_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic i_in_credit,
    input wire logic i_resp_valid,
    input wire logic i_out_credit,
    input wire logic i_op_valid,
    input wire logic i_op_ready,
    input wire logic i_push
);
    timeunit 1ns;
    timeprecision 100ps;

    int credit_count;
    int resp_count;
    int assert_errors = 0;

    // credits granted by the consumer and not yet spent on a response
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_count <= OUT_CREDITS;
        end else begin
            credit_count <= credit_count + int'(i_out_credit) - int'(i_resp_valid);
        end
    end

    // responses pushed into the queue and not yet sent downstream
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_count <= 0;
        end else begin
            resp_count <= resp_count + int'(i_push) - int'(i_resp_valid);
        end
    end

    a_valid_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        i_resp_valid |-> credit_count != 0)
    else begin
        $error("o_resp_valid high with no downstream credit left");
        assert_errors++;
    end

    a_quiet_after_reset: assert property (@(posedge clk)
        !rst_n |=> !i_in_credit && !i_resp_valid)
    else begin
        $error("credit or response output high right after reset");
        assert_errors++;
    end

    a_valid_holds: assert property (@(posedge clk) disable iff (!rst_n)
        i_op_valid && !i_op_ready |=> i_op_valid)
    else begin
        $error("decoded operation withdrawn before it transferred");
        assert_errors++;
    end

    a_no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        i_push |-> resp_count < RESP_DEPTH)
    else begin
        $error("response pushed into a full queue");
        assert_errors++;
    end

endmodule

bind csr_unit_top csr_unit_assertions #(
    .RESP_DEPTH  (RESP_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
) u_assertions (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_in_credit  (o_in_credit),
    .i_resp_valid (o_resp_valid),
    .i_out_credit (i_out_credit),
    .i_op_valid   (op_if.valid),
    .i_op_ready   (op_if.ready),
    .i_push       (push)
);

`default_nettype wire

/* verif/csr_unit_tb.sv */
`default_nettype none

module csr_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import csr_pkg::*;
    import sys_isa_pkg::*;

    localparam int IN_DEPTH    = 2;
    localparam int RESP_DEPTH  = 4;
    localparam int OUT_CREDITS = 2;

    logic  clk;
    logic  rst_n;
    logic  in_valid;
    inst_t in_inst;
    xlen_t in_rs1_data;
    xlen_t in_pc;
    logic  in_credit;
    logic  resp_valid;
    xlen_t resp_rd_data;
    logic  resp_redirect;
    xlen_t resp_target;
    logic  out_credit;

    // one entry per stimulus line
    inst_t st_inst[$];
    xlen_t st_rs1[$];
    xlen_t st_pc[$];
    xlen_t st_rd[$];
    logic  st_redirect[$];
    xlen_t st_target[$];

    int num_lines;
    int rx_count;
    int value_errors;
    int protocol_errors;
    int assert_errors;
    int cycles;
    int cycle_limit;
    bit loaded;
    bit sent_done;

    csr_unit_top #(
        .IN_DEPTH    (IN_DEPTH),
        .RESP_DEPTH  (RESP_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_in_valid      (in_valid),
        .i_in_inst       (in_inst),
        .i_in_rs1_data   (in_rs1_data),
        .i_in_pc         (in_pc),
        .o_in_credit     (in_credit),
        .o_resp_valid    (resp_valid),
        .o_resp_rd_data  (resp_rd_data),
        .o_resp_redirect (resp_redirect),
        .o_resp_target   (resp_target),
        .i_out_credit    (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic check_data(input string name, input int idx, input xlen_t act,
                              input xlen_t exp);
        if (act !== exp) begin
            $display("[FAIL] %s got %h expected %h (response %0d)", name, act, exp, idx);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input int idx, input logic act,
                              input logic exp);
        if (act !== exp) begin
            $display("[FAIL] %s got %h expected %h (response %0d)", name, act, exp, idx);
            value_errors++;
        end
    endtask

    // lines that do not hold six hex words are comments
    task automatic load_stimulus();
        int    fd;
        string line;
        xlen_t w[6];
        fd = $fopen("verif/csr_unit_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            protocol_errors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    if ($sscanf(line, "%h %h %h %h %h %h",
                                w[0], w[1], w[2], w[3], w[4], w[5]) == 6) begin
                        st_inst.push_back(w[0]);
                        st_rs1.push_back(w[1]);
                        st_pc.push_back(w[2]);
                        st_rd.push_back(w[3]);
                        st_redirect.push_back(w[4][0]);
                        st_target.push_back(w[5]);
                    end
                end
            end
            $fclose(fd);
        end
        num_lines = st_inst.size();
    endtask

    task automatic take_response();
        if (rx_count >= num_lines) begin
            $display("unexpected response beyond the %0d expected ones", num_lines);
            protocol_errors++;
        end else begin
            check_data("o_resp_rd_data", rx_count, resp_rd_data, st_rd[rx_count]);
            check_flag("o_resp_redirect", rx_count, resp_redirect, st_redirect[rx_count]);
            check_data("o_resp_target", rx_count, resp_target, st_target[rx_count]);
        end
        rx_count++;
    endtask

    initial begin
        void'($urandom(32'hfbcd_de46));
        rst_n           = 1'b0;
        in_valid        = 1'b0;
        in_inst         = '0;
        in_rs1_data     = '0;
        in_pc           = '0;
        out_credit      = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        rx_count        = 0;
        cycles          = 0;
        sent_done       = 1'b0;
        load_stimulus();
        cycle_limit = 40 * num_lines + 200;
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        wait (sent_done && rx_count >= num_lines);
        // a few more cycles so that a duplicated response would still show up
        repeat (20) @(posedge clk);
        assert_errors = dut.u_assertions.assert_errors;
        $display("errors: value %0d, protocol %0d, assertion %0d",
                 value_errors, protocol_errors, assert_errors);
        if (value_errors + protocol_errors + assert_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // upstream side, one instruction per cycle while a credit is held
    initial begin : sender
        int credits;
        int idx;
        credits = IN_DEPTH;
        idx = 0;
        wait (rst_n === 1'b1);
        while (idx < num_lines) begin
            @(posedge clk);
            #1;
            if (credits > 0) begin
                in_valid    = 1'b1;
                in_inst     = st_inst[idx];
                in_rs1_data = st_rs1[idx];
                in_pc       = st_pc[idx];
                credits--;
                idx++;
            end else begin
                in_valid = 1'b0;
            end
            @(negedge clk);
            if (in_credit) begin
                credits++;
                if (credits > IN_DEPTH) begin
                    $display("upstream credit returned beyond the %0d granted", IN_DEPTH);
                    protocol_errors++;
                end
            end
        end
        @(posedge clk);
        #1 in_valid = 1'b0;
        sent_done = 1'b1;
    end

    // downstream side holds each response a while before it frees the slot
    initial begin : receiver
        int rx_credits;
        int held;
        rx_credits = OUT_CREDITS;
        held = 0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            if (out_credit) begin
                rx_credits++;
            end
            #1;
            if (held > 0 && ($urandom % 4) == 0) begin
                out_credit = 1'b1;
                held--;
            end else begin
                out_credit = 1'b0;
            end
            @(negedge clk);
            if (resp_valid) begin
                if (rx_credits == 0) begin
                    $display("response sent while the downstream side held no credit");
                    protocol_errors++;
                end else begin
                    rx_credits--;
                end
                held++;
                take_response();
            end
        end
    end

    initial begin : watchdog
        wait (loaded);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d of %0d responses received",
                 cycles, rx_count, num_lines);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/csr_unit_stim.txt */
# columns: inst rs1_data pc exp_rd_data exp_redirect exp_target, all hex
# lines that do not hold six hex words are skipped
305092f3 80000100 00000100 00000000 0 00000000
305092f3 80000200 00000104 80000100 0 00000000
342092f3 00000007 00000108 00000000 0 00000000
342022f3 00000000 0000010c 00000007 0 00000000
7c0092f3 12345678 00000110 00000000 0 00000000
7c0022f3 00000000 00000114 00000000 0 00000000
3000a2f3 00000088 00000118 00000000 0 00000000
3001e2f3 ffffffff 0000011c 00000088 0 00000000
3000b2f3 00000080 00000120 0000008b 0 00000000
3000f2f3 ffffffff 00000124 0000000b 0 00000000
300ad2f3 ffffffff 00000128 0000000a 0 00000000
300022f3 00000000 0000012c 00000015 0 00000000
00000073 00000000 00000200 00000000 1 80000200
341022f3 00000000 80000200 00000200 0 00000000
342022f3 00000000 80000204 0000000b 0 00000000
300022f3 00000000 80000208 00001815 0 00000000
341092f3 00000204 8000020c 00000200 0 00000000
30200073 00000000 80000210 00000000 1 00000204
300022f3 00000000 00000204 00000015 0 00000000
00108093 00000055 00000208 00000000 0 00000000
10500073 00000000 0000020c 00000000 0 00000000
300042f3 00000000 00000210 00000000 0 00000000
3420b2f3 ffffffff 00000214 0000000b 0 00000000
342022f3 00000000 00000218 00000000 0 00000000

/* vlog.f */
logic/csr_pkg.sv
logic/sys_isa_pkg.sv
logic/sys_op_if.sv
logic/sys_decode.sv
logic/csr_file.sv
logic/sys_resp_queue.sv
logic/csr_unit_top.sv
verif/csr_unit_assertions.sv
verif/csr_unit_tb.sv

/* Bender.yml */
package:
  name: csr_unit

sources:
  - files:
      - logic/csr_pkg.sv
      - logic/sys_isa_pkg.sv
      - logic/sys_op_if.sv
      - logic/sys_decode.sv
      - logic/csr_file.sv
      - logic/sys_resp_queue.sv
      - logic/csr_unit_top.sv
  - target: test
    files:
      - verif/csr_unit_assertions.sv
      - verif/csr_unit_tb.sv
